// ==== hdl/exec_consts.svh ====
/*
 * Scalar execution stage constants
 * Data, register index and address widths, plus ALU pipeline depth
 */

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and write-back data width
`define EXEC_DATA_W 32

`define EXEC_REG_W 5		// Register index width

`define EXEC_ADDR_W 16		// Memory address width

// Cycles from ALU command to done
`define EXEC_ALU_LAT 2

`endif

// ==== hdl/execOpPkg.sv ====
/*
 * Instruction-side types of the scalar execution stage
 * Operation fields, issued command, write-back token and ALU opcodes
 */

`include "exec_consts.svh"

package execOpPkg;

	typedef logic [`EXEC_DATA_W-1:0] dataT;		// One data word
	typedef logic [`EXEC_REG_W-1:0] regIdxT;	// Register index
	typedef logic [`EXEC_ADDR_W-1:0] addrT;		// Memory address

	//////////////////////////////
	// Operation and command
	//////////////////////////////

	typedef struct packed {
		logic [1:0] opType;		// 0 ALU or move, 3 load/store
		logic [1:0] opClass;	// Move class or unit and direction
		logic [2:0] opCode;		// ALU operation or move kind
	} opFieldT;

	typedef struct packed {
		logic valid;
		opFieldT op;
		regIdxT dst;			// Destination register
		regIdxT srcIdx1;		// Predicate index for predicate moves
		dataT data1;
		dataT data2;
		dataT data3;			// Store data
	} commandT;

	// Travels alongside every write-back
	typedef struct packed {
		logic valid;
		regIdxT dst;
		opFieldT op;
	} wbTokenT;

	//////////////////////////////
	// ALU operations
	//////////////////////////////

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluShl = 3'd5,			// Shift by data2[4:0]
		aluShr = 3'd6,
		aluCmp = 3'd7			// Unsigned less-than, sets predicates
	} aluOpE;

endpackage

// ==== hdl/execMemPkg.sv ====
/*
 * Memory-side types of the scalar execution stage
 * Memory port request and load/store unit FSM states
 */

package execMemPkg;

	// Held until grant
	typedef struct packed {
		logic valid;
		logic write;				// 1 for store
		execOpPkg::addrT addr;
	} memReqT;

	//////////////////////////////
	// Load/store FSM
	//////////////////////////////

	typedef enum logic [1:0] {
		lsIdle      = 2'd0,
		lsRequest   = 2'd1,			// memReq valid, waiting for grant
		lsAccess    = 2'd2,			// Waiting for end of access
		lsWriteBack = 2'd3			// Done cycle
	} lsuStateE;

endpackage

// ==== hdl/scalarAlu.sv ====
/*
 * Two-stage scalar integer ALU
 * Stage 1 captures operands, stage 2 computes and holds the result.
 * Compares also update the two predicate registers. Stall freezes both stages.
 */

`timescale 1ns/1ps
`include "exec_consts.svh"

module scalarAlu (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic request,
	input execOpPkg::commandT command,
	output execOpPkg::wbTokenT wbToken,
	output execOpPkg::dataT wbData,
	output logic predicate0,			// Equal flag of last compare
	output logic predicate1,			// Less-than flag of last compare
	output logic done
);
	import execOpPkg::*;

	logic s1Valid;
	opFieldT s1Op;
	regIdxT s1Dst;
	dataT s1Data1;
	dataT s1Data2;

	logic s2Valid;
	opFieldT s2Op;
	regIdxT s2Dst;
	dataT s2Result;

	aluOpE s1AluOp;
	dataT result;
	logic isEqual;
	logic isLess;

	//////////////////////////////
	// Stage 1
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
		end else if (!stall) begin
			s1Valid <= request;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall && request) begin
			s1Op <= command.op;
			s1Dst <= command.dst;
			s1Data1 <= command.data1;
			s1Data2 <= command.data2;
		end
	end

	//////////////////////////////
	// Stage 2
	//////////////////////////////

	assign s1AluOp = aluOpE'(s1Op.opCode);
	assign isEqual = (s1Data1 == s1Data2);
	assign isLess = (s1Data1 < s1Data2);		// Unsigned

	always_comb begin
		case (s1AluOp)
			aluAdd: result = s1Data1 + s1Data2;
			aluSub: result = s1Data1 - s1Data2;
			aluAnd: result = s1Data1 & s1Data2;
			aluOr: result = s1Data1 | s1Data2;
			aluXor: result = s1Data1 ^ s1Data2;
			aluShl: result = s1Data1 << s1Data2[4:0];
			aluShr: result = s1Data1 >> s1Data2[4:0];
			aluCmp: result = {{(`EXEC_DATA_W-1){1'b0}}, isLess};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s2Valid <= 1'b0;
			predicate0 <= 1'b0;
			predicate1 <= 1'b0;
		end else if (!stall) begin
			s2Valid <= s1Valid;
			if (s1Valid && s1AluOp == aluCmp) begin		// Compare leaving stage 1
				predicate0 <= isEqual;
				predicate1 <= isLess;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall && s1Valid) begin
			s2Op <= s1Op;
			s2Dst <= s1Dst;
			s2Result <= result;
		end
	end

	// Result is held back while stalled
	assign wbToken = '{valid: s2Valid & ~stall, dst: s2Dst, op: s2Op};
	assign wbData = s2Result;
	assign done = wbToken.valid;

	aDoneNotStalled: assert property (@(posedge clock) disable iff (reset)
		stall |-> !done)
		else $error("ALU done raised during stall");

	// Unstalled command reaches done after the full pipeline depth
	aLatency: assert property (@(posedge clock) disable iff (reset)
		(request && !stall) ##1 (!stall) [*(`EXEC_ALU_LAT)] |-> done)
		else $error("ALU result missing after pipeline latency");

endmodule

// ==== hdl/loadStoreUnit.sv ====
/*
 * Single-outstanding load/store unit
 * Drives one memory port with a request, grant, end-of-access handshake
 * and returns the write-back token and load data one cycle after the access ends.
 */

`timescale 1ns/1ps

module loadStoreUnit (
	input logic clock,
	input logic reset,
	input logic request,
	input execOpPkg::commandT command,
	input logic grant,
	input logic endAccess,
	input execOpPkg::dataT loadData,
	output execMemPkg::memReqT memReq,
	output execOpPkg::dataT storeData,
	output execOpPkg::wbTokenT wbToken,
	output execOpPkg::dataT wbData,
	output logic loadStall,
	output logic storeStall,
	output logic done
);
	import execOpPkg::*;
	import execMemPkg::*;

	lsuStateE state;
	logic busy;
	logic accept;

	dataT addrSum;
	logic isWrite;
	addrT reqAddr;
	dataT stData;
	regIdxT wbDst;
	opFieldT wbOp;
	dataT ldData;

	assign busy = (state != lsIdle);
	assign accept = (state == lsIdle) && request;
	assign addrSum = command.data1 + command.data2;

	//////////////////////////////
	// Handshake FSM
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= lsIdle;
		end else begin
			case (state)
				lsIdle: begin
					if (request) begin
						state <= lsRequest;
					end
				end
				lsRequest: begin
					if (grant) begin		// Request taken by memory
						state <= lsAccess;
					end
				end
				lsAccess: begin
					if (endAccess) begin
						state <= lsWriteBack;
					end
				end
				lsWriteBack: state <= lsIdle;
				default: state <= lsIdle;
			endcase
		end
	end

	// Command fields captured on accept
	always_ff @(posedge clock) begin
		if (accept) begin
			isWrite <= command.op.opClass[1];
			reqAddr <= addrT'(addrSum);
			stData <= command.data3;
			wbDst <= command.dst;
			wbOp <= command.op;
		end
	end

	// Load data is valid with endAccess
	always_ff @(posedge clock) begin
		if (state == lsAccess && endAccess) begin
			ldData <= isWrite ? '0 : loadData;		// Stores return no data
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign memReq = '{valid: state == lsRequest, write: isWrite, addr: reqAddr};
	assign storeData = stData;

	assign wbToken = '{valid: state == lsWriteBack, dst: wbDst, op: wbOp};
	assign wbData = ldData;
	assign done = wbToken.valid;

	assign loadStall = busy & ~isWrite;		// Held through the done cycle
	assign storeStall = busy & isWrite;

	aNoReqWhenBusy: assert property (@(posedge clock) disable iff (reset)
		request |-> !busy)
		else $error("Load/store command issued to a busy unit");

	// Request held steady until memory grants it
	aReqStable: assert property (@(posedge clock) disable iff (reset)
		memReq.valid && !grant |=> memReq.valid && $stable(memReq) && $stable(storeData))
		else $error("Memory request changed before grant");

endmodule

// ==== hdl/execUnitScalar.sv ====
/*
 * Scalar execution stage of a vector lane
 * Decodes each command to the ALU, the register-move path or one of
 * the even and odd load/store units. Each path has its own write-back port.
 */

`timescale 1ns/1ps
`include "exec_consts.svh"

module execUnitScalar (
	input logic clock,
	input logic reset,
	input logic stall,
	input execOpPkg::commandT command,
	input logic [1:0] grant,
	input logic [1:0] endAccess,
	input execOpPkg::dataT [1:0] loadData,
	output execMemPkg::memReqT [1:0] memReq,
	output execOpPkg::dataT [1:0] storeData,
	output execOpPkg::wbTokenT wbTokenAlu,
	output execOpPkg::wbTokenT wbTokenMove,
	output execOpPkg::wbTokenT [1:0] wbTokenLs,
	output execOpPkg::dataT wbDataAlu,
	output execOpPkg::dataT wbDataMove,
	output execOpPkg::dataT [1:0] wbDataLs,
	output logic aluDone,
	output logic moveDone,
	output logic [1:0] lsDone,
	output logic ldStall,
	output logic stStall
);
	import execOpPkg::*;

	logic aluReq;
	logic moveReq;
	logic commonMove;
	logic predMove;
	logic [1:0] lsReq;

	logic predicate0;
	logic predicate1;
	dataT moveResult;

	logic moveValid;
	regIdxT moveDst;
	opFieldT moveOp;
	dataT moveData;

	logic [1:0] ldStallUnit;
	logic [1:0] stStallUnit;

	//////////////////////////////
	// Decode
	//////////////////////////////

	assign moveReq = command.valid && command.op.opType == 2'd0 && command.op.opClass == 2'd3;
	assign aluReq = command.valid && command.op.opType == 2'd0 && command.op.opClass != 2'd3;
	assign commonMove = moveReq && command.op.opCode == 3'd1;
	assign predMove = moveReq && command.op.opCode == 3'd2;

	assign lsReq[0] = command.valid && command.op.opType == 2'd3 && !command.op.opClass[0];
	assign lsReq[1] = command.valid && command.op.opType == 2'd3 && command.op.opClass[0];

	//////////////////////////////
	// Register move path
	//////////////////////////////

	always_comb begin
		moveResult = '0;
		if (commonMove) begin
			moveResult = command.data1;
		end else if (predMove && command.srcIdx1 == regIdxT'(0)) begin
			moveResult = {{(`EXEC_DATA_W-1){1'b0}}, predicate0};
		end else if (predMove && command.srcIdx1 == regIdxT'(1)) begin
			moveResult = {{(`EXEC_DATA_W-1){1'b0}}, predicate1};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			moveValid <= 1'b0;
		end else begin
			moveValid <= moveReq;		// Not affected by stall
		end
	end

	always_ff @(posedge clock) begin
		moveDst <= command.dst;
		moveOp <= command.op;
		moveData <= moveResult;
	end

	assign wbTokenMove = '{valid: moveValid, dst: moveDst, op: moveOp};
	assign wbDataMove = moveData;
	assign moveDone = wbTokenMove.valid;

	//////////////////////////////
	// Execution units
	//////////////////////////////

	scalarAlu aluInst (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.request(aluReq),
		.command(command),
		.wbToken(wbTokenAlu),
		.wbData(wbDataAlu),
		.predicate0(predicate0),
		.predicate1(predicate1),
		.done(aluDone)
	);

	loadStoreUnit lsuEven (
		.clock(clock),
		.reset(reset),
		.request(lsReq[0]),
		.command(command),
		.grant(grant[0]),
		.endAccess(endAccess[0]),
		.loadData(loadData[0]),
		.memReq(memReq[0]),
		.storeData(storeData[0]),
		.wbToken(wbTokenLs[0]),
		.wbData(wbDataLs[0]),
		.loadStall(ldStallUnit[0]),
		.storeStall(stStallUnit[0]),
		.done(lsDone[0])
	);

	loadStoreUnit lsuOdd (
		.clock(clock),
		.reset(reset),
		.request(lsReq[1]),
		.command(command),
		.grant(grant[1]),
		.endAccess(endAccess[1]),
		.loadData(loadData[1]),
		.memReq(memReq[1]),
		.storeData(storeData[1]),
		.wbToken(wbTokenLs[1]),
		.wbData(wbDataLs[1]),
		.loadStall(ldStallUnit[1]),
		.storeStall(stStallUnit[1]),
		.done(lsDone[1])
	);

	assign ldStall = |ldStallUnit;		// Either unit loading
	assign stStall = |stStallUnit;

	aOnePath: assert property (@(posedge clock) disable iff (reset)
		$onehot0({aluReq, moveReq, lsReq}))
		else $error("Command decoded to more than one path");

endmodule

// ==== dv/execUnitScalarTb.sv ====
/*
 * Directed testbench for the scalar execution stage
 * Drives ALU, move, load/store, back-pressure and stall tests and
 * models both memory ports with random grant and end-of-access delays.
 */

`timescale 1ns/1ps

module execUnitScalarTb;
	import execOpPkg::*;
	import execMemPkg::*;

	localparam int clockPeriod = 4;
	localparam int testCount = 6;
	localparam int cyclesPerTest = 50;
	localparam int doneLimit = 20;		// Cycles to wait for any done strobe
	localparam int memDepth = 256;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic stall = 1'b0;
	commandT command = '0;
	logic [1:0] grant = '0;
	logic [1:0] endAccess = '0;
	dataT [1:0] loadData = '0;
	memReqT [1:0] memReq;
	dataT [1:0] storeData;
	wbTokenT wbTokenAlu;
	wbTokenT wbTokenMove;
	wbTokenT [1:0] wbTokenLs;
	dataT wbDataAlu;
	dataT wbDataMove;
	dataT [1:0] wbDataLs;
	logic aluDone;
	logic moveDone;
	logic [1:0] lsDone;
	logic ldStall;
	logic stStall;

	logic [31:0] lfsrState [2];			// Stream 0 for tests, 1 for memory delays
	dataT memWords [2][memDepth];
	int phase [2];						// 0 idle, 1 before grant, 2 before end
	int delay [2];
	logic [7:0] portAddr [2];
	int grantHold = 0;					// Extra grant delay for back-pressure

	execUnitScalar execUnitScalar_inst (.*);

	initial begin
		forever #(clockPeriod / 2) clock = ~clock;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] randBits(input int stream, input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState[stream] = (lfsrState[stream] >> 1) ^
				(lfsrState[stream][0] ? 32'h8020_0003 : 32'h0);	// Galois taps
			value = {value[30:0], lfsrState[stream][0]};
		end
		return value;
	endfunction

	function automatic dataT fillWord(input int port, input int addr);
		return {16'(addr) ^ 16'h3c5a, 8'(port + 1), 8'(addr)};
	endfunction

	function automatic commandT makeCommand(input logic [1:0] opType, input logic [1:0] opClass,
		input logic [2:0] opCode, input regIdxT dst, input regIdxT srcIdx,
		input dataT d1, input dataT d2, input dataT d3);
		commandT cmd;
		cmd.valid = 1'b1;
		cmd.op.opType = opType;
		cmd.op.opClass = opClass;
		cmd.op.opCode = opCode;
		cmd.dst = dst;
		cmd.srcIdx1 = srcIdx;
		cmd.data1 = d1;
		cmd.data2 = d2;
		cmd.data3 = d3;
		return cmd;
	endfunction

	function automatic dataT aluResult(input int op, input dataT a, input dataT b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			6: return a >> b[4:0];
			default: return (a < b) ? 32'd1 : 32'd0;	// Unsigned compare
		endcase
	endfunction

	function automatic logic doneOf(input int path);
		case (path)
			0: return aluDone;
			1: return moveDone;
			2: return lsDone[0];
			default: return lsDone[1];
		endcase
	endfunction

	task automatic stopRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic stopWith(input string reason);
		$display("%s", reason);
		stopRun();
	endtask

	task automatic compareValues(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
			stopRun();
		end
	endtask

	task automatic issue(input commandT cmd);
		@(negedge clock);
		command = cmd;
	endtask

	// Counts cycles to done and can stall from the cycle after issue
	task automatic waitDone(input int path, input int stallCycles, output int cycles);
		logic doneNow;
		cycles = 0;
		doneNow = 1'b0;
		while (!doneNow) begin
			@(negedge clock);
			cycles++;
			doneNow = doneOf(path);
			if (stall && aluDone) begin
				stopWith("ALU done was raised while stall was high");
			end
			if (cycles == 1) begin
				command.valid = 1'b0;
				stall = (stallCycles > 0);
			end
			if (cycles == 1 + stallCycles) begin
				stall = 1'b0;
			end
			if (cycles > doneLimit) begin
				stopWith("No done strobe arrived for an issued command");
			end
		end
	endtask

	task automatic access(input int port, input logic write, input dataT a, input dataT b,
		input dataT d, input regIdxT dst, input dataT expected, input string testName);
		int cycles;
		issue(makeCommand(2'd3, {write, 1'(port)}, 3'd0, dst, 5'd0, a, b, d));
		waitDone(2 + port, 0, cycles);
		compareValues(testName, dst, wbTokenLs[port].dst);
		compareValues(testName, {2'd3, write, 1'(port), 3'd0}, wbTokenLs[port].op);
		compareValues(testName, expected, wbDataLs[port]);
		compareValues(testName, 0, lsDone[1 - port]);	// Other port stays quiet
	endtask

	task automatic runMove(input logic [2:0] opCode, input regIdxT idx, input dataT a,
		input dataT expected, input string testName);
		int cycles;
		issue(makeCommand(2'd0, 2'd3, opCode, 5'd12, idx, a, '0, '0));
		waitDone(1, 0, cycles);
		compareValues(testName, 1, cycles);
		compareValues(testName, 12, wbTokenMove.dst);
		compareValues(testName, {2'd0, 2'd3, opCode}, wbTokenMove.op);
		compareValues(testName, expected, wbDataMove);
	endtask

	task automatic runAlu(input int op, input dataT a, input dataT b, input int stallCycles,
		input string testName);
		int cycles;
		issue(makeCommand(2'd0, 2'd0, 3'(op), 5'(op + 3), 5'd0, a, b, '0));
		waitDone(0, stallCycles, cycles);
		compareValues(testName, 2 + stallCycles, cycles);
		compareValues(testName, op + 3, wbTokenAlu.dst);
		compareValues(testName, {2'd0, 2'd0, 3'(op)}, wbTokenAlu.op);
		compareValues(testName, aluResult(op, a, b), wbDataAlu);
	endtask

	//////////////////////////////
	// Memory port models
	//////////////////////////////

	always @(negedge clock) begin
		if (reset) begin
			grant = '0;
			endAccess = '0;
			loadData = '0;
			for (int p = 0; p < 2; p++) begin
				phase[p] = 0;
				for (int a = 0; a < memDepth; a++) begin
					memWords[p][a] = fillWord(p, a);
				end
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				grant[p] = 1'b0;
				endAccess[p] = 1'b0;
				if (phase[p] == 0 && memReq[p].valid) begin
					if (memReq[p].addr >= memDepth) begin
						stopWith("Memory request address lies outside the port model");
					end
					delay[p] = int'(randBits(1, 2)) + grantHold;
					phase[p] = 1;
				end
				if (phase[p] == 1) begin
					if (delay[p] == 0) begin
						grant[p] = 1'b1;
						portAddr[p] = memReq[p].addr[7:0];
						if (memReq[p].write) begin
							memWords[p][portAddr[p]] = storeData[p];
						end
						delay[p] = int'(randBits(1, 2));
						phase[p] = 2;
					end else begin
						delay[p]--;
					end
				end else if (phase[p] == 2) begin
					if (delay[p] == 0) begin
						endAccess[p] = 1'b1;
						loadData[p] = memWords[p][portAddr[p]];	// Valid with endAccess
						phase[p] = 0;
					end else begin
						delay[p]--;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic testAluOps();
		for (int op = 0; op < 8; op++) begin
			runAlu(op, randBits(0, 32), randBits(0, 32), 0, "aluOps");
		end
	endtask

	task automatic testMoves();
		dataT a;
		a = randBits(0, 32);
		runMove(3'd1, 5'd0, a, a, "moves common");
		a = randBits(0, 32);
		runAlu(7, a, a, 0, "moves compare equal");
		runMove(3'd2, 5'd0, '0, 32'd1, "moves predicate0");
		runMove(3'd2, 5'd1, '0, 32'd0, "moves predicate1");
		a = randBits(0, 31);
		runAlu(7, a, a + 1, 0, "moves compare less");
		runMove(3'd2, 5'd0, '0, 32'd0, "moves predicate0");
		runMove(3'd2, 5'd1, '0, 32'd1, "moves predicate1");
		runMove(3'd2, 5'd2, '0, 32'd0, "moves other index");
		runMove(3'd2, 5'd31, '0, 32'd0, "moves other index");
	endtask

	task automatic testLoads();
		dataT a;
		dataT b;
		for (int i = 0; i < 4; i++) begin
			a = randBits(0, 32) & 32'hffff_007f;	// Upper bits dropped from address
			b = randBits(0, 7);
			access(i % 2, 1'b0, a, b, '0, 5'(20 + i), memWords[i % 2][8'(a + b)], "loads");
		end
	endtask

	task automatic testStores();
		dataT a;
		dataT b;
		dataT d;
		for (int p = 0; p < 2; p++) begin
			a = randBits(0, 32) & 32'hffff_007f;
			b = randBits(0, 7);
			d = randBits(0, 32);
			access(p, 1'b1, a, b, d, 5'd14, '0, "stores write");
			compareValues("stores memory", d, memWords[p][8'(a + b)]);
			access(p, 1'b0, a, b, '0, 5'd15, d, "stores readBack");
		end
	endtask

	task automatic testBackPressure(input int port, input logic write);
		memReqT firstReq;
		dataT firstData;
		logic seen;
		logic doneNow;
		int cycles;
		int reqCycles;
		seen = 1'b0;
		doneNow = 1'b0;
		cycles = 0;
		reqCycles = 0;
		grantHold = 3;
		issue(makeCommand(2'd3, {write, 1'(port)}, 3'd0, 5'd9, 5'd0,
			randBits(0, 32) & 32'hffff_007f, randBits(0, 7), randBits(0, 32)));
		while (!doneNow) begin
			@(negedge clock);
			cycles++;
			if (cycles == 1) begin
				command.valid = 1'b0;
			end
			doneNow = lsDone[port];
			compareValues("backPressure stall", {!write, write}, {ldStall, stStall});
			if (memReq[port].valid) begin
				if (!seen) begin
					firstReq = memReq[port];
					firstData = storeData[port];
					seen = 1'b1;
				end
				reqCycles++;
				compareValues("backPressure memReq", firstReq, memReq[port]);
				compareValues("backPressure storeData", firstData, storeData[port]);
			end
			if (cycles > doneLimit) begin
				stopWith("Load/store unit never finished its delayed access");
			end
		end
		grantHold = 0;
		compareValues("backPressure grantDelay", 1, reqCycles >= 4);
		@(negedge clock);
		compareValues("backPressure release", 0, {ldStall, stStall});
	endtask

	task automatic testStall();
		runAlu(0, randBits(0, 32), randBits(0, 32), 1, "stall one");
		runAlu(4, randBits(0, 32), randBits(0, 32), 4, "stall four");
	endtask

	initial begin
		#(testCount * cyclesPerTest * clockPeriod);
		$display("Timeout: the tests did not finish in the allowed time");
		stopRun();
	end

	initial begin
		lfsrState[0] = 32'h4b42_ebeb;
		lfsrState[1] = 32'h4b42_ebeb;
		repeat (3) @(negedge clock);
		reset = 1'b0;
		compareValues("reset", 0, {aluDone, moveDone, lsDone, ldStall, stStall,
			memReq[0].valid, memReq[1].valid});
		testAluOps();
		testMoves();
		testLoads();
		testStores();
		testBackPressure(0, 1'b0);
		testBackPressure(1, 1'b1);
		testStall();
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/execOpPkg.sv
hdl/execMemPkg.sv
hdl/scalarAlu.sv
hdl/loadStoreUnit.sv
hdl/execUnitScalar.sv
dv/execUnitScalarTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module execUnitScalarTb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
